// File: plic_arb.f
+incdir+common
common/plic_pkg.sv
design/plic_prio_sel.sv
arb/plic_granu_arb.sv
arb/plic_arb_tree.sv
gateway/plic_gateway.sv
design/plic_hart_ctrl.sv
design/plic_top.sv
verification/plic_clk_gen.sv
verification/plic_tb.sv

// File: verification/plic_tb.sv
// plic testbench
// table-driven check of the single-hart plic core. each row writes
// priorities and a threshold, raises sources, claims them against a
// reference model, completes them and drains the sources that pend again
`timescale 1ns/1ps
`default_nettype none

`include "plic_defines.svh"

module plic_tb;

  localparam int SRC_NUM     = `PLIC_SRC_NUM;
  localparam int NUM_DIR     = 6;
  localparam int NUM_ROWS    = 10;
  localparam int MAX_WR      = 6;
  // setup plus claim, complete and drain per source
  localparam int ROW_CYCLES  = 40 + 9 * SRC_NUM;
  localparam int WATCHDOG_NS = (NUM_ROWS * ROW_CYCLES + 100) * 20;

  // one priority write of a row
  typedef struct packed {
    plic_pkg::plic_id_t   id;
    plic_pkg::plic_prio_t prio;
  } prio_wr_t;

  logic                 clk;
  logic                 rst_n;
  logic [SRC_NUM-1:0]   src;
  logic                 prio_we;
  plic_pkg::plic_id_t   prio_id;
  plic_pkg::plic_prio_t prio_wdata;
  logic                 thresh_we;
  plic_pkg::plic_prio_t thresh_wdata;
  logic                 claim;
  plic_pkg::plic_id_t   claim_id;
  logic                 complete;
  plic_pkg::plic_id_t   complete_id;
  logic                 irq;

  //******************************
  // stimulus table
  //******************************
  logic [SRC_NUM-1:0]   row_src    [NUM_ROWS];
  plic_pkg::plic_prio_t row_thresh [NUM_ROWS];
  prio_wr_t             row_wr     [NUM_ROWS][MAX_WR];
  // expected claim order ending in id 0
  plic_pkg::plic_id_t   row_exp    [NUM_ROWS][SRC_NUM];
  bit                   row_fixed  [NUM_ROWS];

  // priorities as the dut holds them
  plic_pkg::plic_prio_t cur_prio [SRC_NUM];
  logic [SRC_NUM-1:0]   taken;
  logic [SRC_NUM-1:0]   drained;
  logic [SRC_NUM-1:0]   seq_mask;
  plic_pkg::plic_id_t   exp_id;
  logic                 exp_irq;
  int                   err_cnt;
  int                   err_before;
  int                   pass_cnt;
  int                   fail_cnt;

  plic_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  plic_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .src          (src),
    .prio_we      (prio_we),
    .prio_id      (prio_id),
    .prio_wdata   (prio_wdata),
    .thresh_we    (thresh_we),
    .thresh_wdata (thresh_wdata),
    .claim        (claim),
    .claim_id     (claim_id),
    .complete     (complete),
    .complete_id  (complete_id),
    .irq          (irq)
  );

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("Error t=%0t %s got %0d expected %0d", $time, name, got, exp);
    err_cnt++;
  endtask

  // highest priority above th wins
  // strict compare keeps the lowest id on a tie
  function automatic plic_pkg::plic_id_t next_expected_id(input logic [SRC_NUM-1:0] cand,
                                                          input plic_pkg::plic_prio_t th);
    plic_pkg::plic_id_t   best_id;
    plic_pkg::plic_prio_t best_prio;
    best_id   = '0;
    best_prio = th;
    for (int i = 0; i < SRC_NUM; i++)
    begin
      if (cand[i] && (cur_prio[i] > best_prio))
      begin
        best_id   = plic_pkg::plic_id_t'(i + 1);
        best_prio = cur_prio[i];
      end
    end
    return best_id;
  endfunction

  task automatic load_table();
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      row_src[r]    = '0;
      row_thresh[r] = '0;
      row_fixed[r]  = (r < NUM_DIR);
      for (int w = 0; w < MAX_WR; w++)
      begin
        row_wr[r][w] = '0;
      end
      for (int e = 0; e < SRC_NUM; e++)
      begin
        row_exp[r][e] = '0;
      end
    end
    // id 1 high at priority 0
    row_src[0] = 16'h0001;
    // id 1 at priority 3
    row_src[1]    = 16'h0001;
    row_wr[1][0]  = {5'd1, 3'd3};
    row_exp[1][0] = 5'd1;
    // one or two sources in every granule
    row_src[2]    = 16'h844A;
    row_wr[2][0]  = {5'd2, 3'd2};
    row_wr[2][1]  = {5'd4, 3'd1};
    row_wr[2][2]  = {5'd7, 3'd5};
    row_wr[2][3]  = {5'd11, 3'd5};
    row_wr[2][4]  = {5'd16, 3'd7};
    row_exp[2][0] = 5'd16;
    row_exp[2][1] = 5'd7;
    row_exp[2][2] = 5'd11;
    row_exp[2][3] = 5'd2;
    row_exp[2][4] = 5'd4;
    // equal priority claimed in rising id order
    row_src[3]    = 16'h2114;
    row_wr[3][0]  = {5'd14, 3'd4};
    row_wr[3][1]  = {5'd9, 3'd4};
    row_wr[3][2]  = {5'd5, 3'd4};
    row_wr[3][3]  = {5'd3, 3'd4};
    row_exp[3][0] = 5'd3;
    row_exp[3][1] = 5'd5;
    row_exp[3][2] = 5'd9;
    row_exp[3][3] = 5'd14;
    // threshold 3 hides ids 1 and 6
    row_src[4]    = 16'h4821;
    row_thresh[4] = 3'd3;
    row_wr[4][0]  = {5'd1, 3'd2};
    row_wr[4][1]  = {5'd6, 3'd3};
    row_wr[4][2]  = {5'd12, 3'd5};
    row_wr[4][3]  = {5'd15, 3'd6};
    row_exp[4][0] = 5'd15;
    row_exp[4][1] = 5'd12;
    // everything at or below the threshold
    row_src[5]    = 16'h1080;
    row_thresh[5] = 3'd4;
    row_wr[5][0]  = {5'd8, 3'd4};
    row_wr[5][1]  = {5'd13, 3'd2};
    // random rows checked against the model only
    for (int r = NUM_DIR; r < NUM_ROWS; r++)
    begin
      row_src[r]    = SRC_NUM'($urandom);
      row_thresh[r] = plic_pkg::plic_prio_t'($urandom % 3);
      for (int w = 0; w < MAX_WR; w++)
      begin
        row_wr[r][w] = {plic_pkg::plic_id_t'(($urandom % SRC_NUM) + 1),
                        plic_pkg::plic_prio_t'($urandom % 8)};
      end
    end
  endtask

  task automatic drive_thresh(input plic_pkg::plic_prio_t value);
    thresh_we    = 1'b1;
    thresh_wdata = value;
    @(negedge clk);
    thresh_we = 1'b0;
  endtask

  // writes all sixteen registers
  // unlisted sources get priority 0
  task automatic write_prios(input int r);
    for (int i = 0; i < SRC_NUM; i++)
    begin
      cur_prio[i] = '0;
    end
    for (int w = 0; w < MAX_WR; w++)
    begin
      if (row_wr[r][w].id != '0)
      begin
        cur_prio[row_wr[r][w].id - 1] = row_wr[r][w].prio;
      end
    end
    for (int i = 0; i < SRC_NUM; i++)
    begin
      prio_we    = 1'b1;
      prio_id    = plic_pkg::plic_id_t'(i + 1);
      prio_wdata = cur_prio[i];
      @(negedge clk);
    end
    prio_we = 1'b0;
  endtask

  //******************************
  // claim loop
  //******************************
  // claims while irq is high and checks each id and the blackout
  task automatic run_claims(input logic [SRC_NUM-1:0] cand, input plic_pkg::plic_prio_t th,
                            input bit complete_now, output logic [SRC_NUM-1:0] got_mask);
    plic_pkg::plic_id_t want_id;
    plic_pkg::plic_id_t got_id;
    bit                 active;
    got_mask = '0;
    active   = 1'b1;
    for (int n = 0; (n <= SRC_NUM) && active; n++)
    begin
      want_id = next_expected_id(cand & ~got_mask, th);
      if (irq !== (want_id != '0))
      begin
        report_mismatch("irq", irq, want_id != '0);
      end
      if (irq !== 1'b1)
      begin
        active = 1'b0;
      end
      else
      begin
        got_id = claim_id;
        if (got_id != want_id)
        begin
          report_mismatch("claim_id", got_id, want_id);
        end
        if ((got_id != '0) && got_mask[got_id-1])
        begin
          $display("id %0d was returned twice without a complete", got_id);
          err_cnt++;
        end
        claim = 1'b1;
        @(negedge clk);
        claim = 1'b0;
        if (got_id != '0)
        begin
          got_mask[got_id-1] = 1'b1;
        end
        if (complete_now)
        begin
          complete    = 1'b1;
          complete_id = got_id;
        end
        // irq masked for three cycles after the claim edge
        for (int k = 0; k < 3; k++)
        begin
          if (irq !== 1'b0)
          begin
            report_mismatch("irq", irq, 0);
          end
          @(negedge clk);
          complete    = 1'b0;
          complete_id = '0;
        end
      end
    end
  endtask

  //******************************
  // main sequence
  //******************************
  initial
  begin
    src          = '0;
    prio_we      = 1'b0;
    prio_id      = '0;
    prio_wdata   = '0;
    thresh_we    = 1'b0;
    thresh_wdata = '0;
    claim        = 1'b0;
    complete     = 1'b0;
    complete_id  = '0;
    err_cnt      = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    void'($urandom(32'h16111dd2));
    load_table();
    @(posedge rst_n);
    @(negedge clk);

    // idle after reset and a claim returns 0
    err_before = err_cnt;
    if (irq !== 1'b0)
    begin
      report_mismatch("irq", irq, 0);
    end
    if (claim_id !== '0)
    begin
      report_mismatch("claim_id", claim_id, 0);
    end
    claim = 1'b1;
    @(negedge clk);
    claim = 1'b0;
    if (irq !== 1'b0)
    begin
      report_mismatch("irq", irq, 0);
    end
    $display("reset: %s", (err_cnt == err_before) ? "ok" : "failed");
    if (err_cnt == err_before)
    begin
      pass_cnt++;
    end
    else
    begin
      fail_cnt++;
    end

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      err_before = err_cnt;
      write_prios(r);
      drive_thresh(row_thresh[r]);
      // model against the fixed column
      if (row_fixed[r])
      begin
        seq_mask = '0;
        for (int e = 0; e < SRC_NUM; e++)
        begin
          exp_id = next_expected_id(row_src[r] & ~seq_mask, row_thresh[r]);
          if (exp_id != row_exp[r][e])
          begin
            $display("row %0d: reference model gives id %0d where the table lists %0d",
                     r, exp_id, row_exp[r][e]);
            err_cnt++;
          end
          if (exp_id != '0)
          begin
            seq_mask[exp_id-1] = 1'b1;
          end
        end
      end
      // irq rises after the third edge
      src    = row_src[r];
      exp_id = next_expected_id(row_src[r], row_thresh[r]);
      for (int c = 1; c <= 4; c++)
      begin
        @(negedge clk);
        exp_irq = (c >= 3) && (exp_id != '0);
        if (irq !== exp_irq)
        begin
          report_mismatch("irq", irq, exp_irq);
        end
      end
      // threshold 7 masks every level
      if (exp_id != '0)
      begin
        drive_thresh(3'd7);
        if (irq !== 1'b0)
        begin
          report_mismatch("irq", irq, 0);
        end
        drive_thresh(row_thresh[r]);
        if (irq !== 1'b1)
        begin
          report_mismatch("irq", irq, 1);
        end
      end
      run_claims(row_src[r], row_thresh[r], 1'b0, taken);
      for (int i = 0; i < SRC_NUM; i++)
      begin
        if (taken[i])
        begin
          complete    = 1'b1;
          complete_id = plic_pkg::plic_id_t'(i + 1);
          @(negedge clk);
        end
      end
      complete    = 1'b0;
      complete_id = '0;
      // completed sources still high pend again here
      @(negedge clk);
      src = '0;
      drive_thresh('0);
      // tree catches up with the last pend
      @(negedge clk);
      run_claims(row_src[r], '0, 1'b1, drained);
      if ((drained & taken) != taken)
      begin
        $display("row %0d: a completed source was not claimed again", r);
        err_cnt++;
      end
      $display("row %0d: %0d claimed, %0d claimed again after complete, %s", r,
               $countones(taken), $countones(drained),
               (err_cnt == err_before) ? "ok" : "failed");
      if (err_cnt == err_before)
      begin
        pass_cnt++;
      end
      else
      begin
        fail_cnt++;
      end
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/plic_clk_gen.sv
// plic testbench clock and reset
// free-running clock with a 20 ns period, rst_n held low for
// the first five cycles and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module plic_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  // release away from the sampling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: design/plic_top.sv
// plic arbitration core, single hart
// gateway feeds the two-level arbitration tree, whose registered
// winner goes to the hart controller. claims and completes loop
// back from the hart controller into the gateway
`timescale 1ns/1ps
`default_nettype none

`include "plic_defines.svh"

module plic_top (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [`PLIC_SRC_NUM-1:0] src,
  input  wire logic                     prio_we,
  input  wire plic_pkg::plic_id_t       prio_id,
  input  wire plic_pkg::plic_prio_t     prio_wdata,
  input  wire logic                     thresh_we,
  input  wire plic_pkg::plic_prio_t     thresh_wdata,
  input  wire logic                     claim,
  output plic_pkg::plic_id_t            claim_id,
  input  wire logic                     complete,
  input  wire plic_pkg::plic_id_t       complete_id,
  output logic                          irq
);

  // gateway to tree
  plic_pkg::plic_int_info_t int_info [`PLIC_SRC_NUM];
  // tree to hart controller
  plic_pkg::plic_int_info_t winner;
  // hart controller back to gateway
  logic                     claim_hit;
  plic_pkg::plic_id_t       claim_hit_id;
  logic                     done;
  plic_pkg::plic_id_t       done_id;

  plic_gateway u_gateway (
    .clk          (clk),
    .rst_n        (rst_n),
    .src          (src),
    .prio_we      (prio_we),
    .prio_id      (prio_id),
    .prio_wdata   (prio_wdata),
    .claim_hit    (claim_hit),
    .claim_hit_id (claim_hit_id),
    .done         (done),
    .done_id      (done_id),
    .int_info     (int_info)
  );

  plic_arb_tree u_arb_tree (
    .clk     (clk),
    .rst_n   (rst_n),
    .int_in  (int_info),
    .int_out (winner)
  );

  plic_hart_ctrl u_hart_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .winner       (winner),
    .thresh_we    (thresh_we),
    .thresh_wdata (thresh_wdata),
    .claim        (claim),
    .complete     (complete),
    .complete_id  (complete_id),
    .irq          (irq),
    .claim_id     (claim_id),
    .claim_hit    (claim_hit),
    .claim_hit_id (claim_hit_id),
    .done         (done),
    .done_id      (done_id)
  );

endmodule

`default_nettype wire

// File: design/plic_hart_ctrl.sv
// plic hart controller
// threshold compare and interrupt line for a single hart, claim
// and complete handling, and a short blackout after every claim
// that hides winners still travelling through the tree
`timescale 1ns/1ps
`default_nettype none

module plic_hart_ctrl (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire plic_pkg::plic_int_info_t winner,
  input  wire logic                     thresh_we,
  input  wire plic_pkg::plic_prio_t     thresh_wdata,
  input  wire logic                     claim,
  input  wire logic                     complete,
  input  wire plic_pkg::plic_id_t       complete_id,
  output logic                          irq,
  output plic_pkg::plic_id_t            claim_id,
  output logic                          claim_hit,
  output plic_pkg::plic_id_t            claim_hit_id,
  output logic                          done,
  output plic_pkg::plic_id_t            done_id
);

  plic_pkg::plic_prio_t thresh_q;
  logic [1:0]           blk_cnt_q;
  logic                 above_thresh;

  //******************************
  // threshold
  //******************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      thresh_q <= '0;
    end
    else if (thresh_we)
    begin
      thresh_q <= thresh_wdata;
    end
  end

  // strictly above threshold
  assign above_thresh = winner.req && (winner.prio > thresh_q);

  //******************************
  // claim blackout
  //******************************
  // 3 cycles covers the two tree stages after the gateway update
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      blk_cnt_q <= 2'd0;
    end
    else if (claim_hit)
    begin
      blk_cnt_q <= 2'd3;
    end
    else if (blk_cnt_q != 2'd0)
    begin
      blk_cnt_q <= blk_cnt_q - 2'd1;
    end
  end

  assign irq = above_thresh && (blk_cnt_q == 2'd0);

  // claim answers in the same cycle
  assign claim_id     = irq ? winner.id : '0;
  assign claim_hit    = claim && irq;
  assign claim_hit_id = claim_id;

  // complete with id 0 is dropped
  assign done    = complete && (complete_id != '0);
  assign done_id = complete_id;

endmodule

`default_nettype wire

// File: gateway/plic_gateway.sv
// plic gateway
// per-source priority registers and the pending / in-service bits
// of level-sensitive sources. packs each source into an arbiter
// candidate with its fixed id (index plus one)
`timescale 1ns/1ps
`default_nettype none

`include "plic_defines.svh"

module plic_gateway (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [`PLIC_SRC_NUM-1:0] src,
  input  wire logic                     prio_we,
  input  wire plic_pkg::plic_id_t       prio_id,
  input  wire plic_pkg::plic_prio_t     prio_wdata,
  input  wire logic                     claim_hit,
  input  wire plic_pkg::plic_id_t       claim_hit_id,
  input  wire logic                     done,
  input  wire plic_pkg::plic_id_t       done_id,
  output plic_pkg::plic_int_info_t      int_info [`PLIC_SRC_NUM]
);

  localparam int SRC_NUM = `PLIC_SRC_NUM;

  plic_pkg::plic_prio_t prio_q [SRC_NUM];
  logic [SRC_NUM-1:0]   pend_q;
  logic [SRC_NUM-1:0]   serv_q;

  //******************************
  // per-source state
  //******************************
  for (genvar i = 0; i < SRC_NUM; i++)
  begin : g_src
    localparam plic_pkg::plic_id_t SRC_ID = plic_pkg::plic_id_t'(i + 1);

    // priority register, ids outside 1..16 never match
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        prio_q[i] <= '0;
      end
      else if (prio_we && (prio_id == SRC_ID))
      begin
        prio_q[i] <= prio_wdata;
      end
    end

    // pending latches the level, claim moves it to in service
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        pend_q[i] <= 1'b0;
        serv_q[i] <= 1'b0;
      end
      else
      begin
        if (done && (done_id == SRC_ID))
        begin
          serv_q[i] <= 1'b0;
        end
        if (claim_hit && (claim_hit_id == SRC_ID))
        begin
          pend_q[i] <= 1'b0;
          serv_q[i] <= 1'b1;
        end
        else if (src[i] && (prio_q[i] != '0) && !serv_q[i])
        begin
          pend_q[i] <= 1'b1;
        end
      end
    end

    // candidate packing
    // priority 0 masks a bit that pended earlier
    assign int_info[i].req  = pend_q[i] && (prio_q[i] != '0);
    assign int_info[i].id   = SRC_ID;
    assign int_info[i].prio = prio_q[i];
  end

endmodule

`default_nettype wire

// File: arb/plic_arb_tree.sv
// plic arbitration tree
// two levels of granule arbiters reduce sixteen candidates to one.
// a register follows the first level and another holds the final
// winner, so the tree has a latency of two cycles
`timescale 1ns/1ps
`default_nettype none

`include "plic_defines.svh"

module plic_arb_tree (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire plic_pkg::plic_int_info_t int_in [`PLIC_SRC_NUM],
  output plic_pkg::plic_int_info_t      int_out
);

  localparam int SEL_NUM   = `PLIC_SEL_NUM;
  // number of first-level granules
  localparam int GRANU_NUM = `PLIC_SRC_NUM >> `PLIC_SEL_BIT;

  plic_pkg::plic_int_info_t lvl1_win [GRANU_NUM];
  plic_pkg::plic_int_info_t lvl1_q   [GRANU_NUM];
  plic_pkg::plic_int_info_t lvl2_win;

  //******************************
  // level 1
  //******************************
  for (genvar g = 0; g < GRANU_NUM; g++)
  begin : g_lvl1
    plic_pkg::plic_int_info_t grp_in [SEL_NUM];

    // four neighbouring sources per granule
    for (genvar e = 0; e < SEL_NUM; e++)
    begin : g_grp
      assign grp_in[e] = int_in[g*SEL_NUM+e];
    end

    plic_granu_arb u_lvl1_arb (
      .int_in  (grp_in),
      .int_out (lvl1_win[g])
    );
  end

  // stage register, loads every cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int g = 0; g < GRANU_NUM; g++)
      begin
        lvl1_q[g] <= '0;
      end
    end
    else
    begin
      lvl1_q <= lvl1_win;
    end
  end

  //******************************
  // level 2
  //******************************
  // granule order matches id order, lowest id still wins ties
  plic_granu_arb u_lvl2_arb (
    .int_in  (lvl1_q),
    .int_out (lvl2_win)
  );

  // output register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      int_out <= '0;
    end
    else
    begin
      int_out <= lvl2_win;
    end
  end

endmodule

`default_nettype wire

// File: arb/plic_granu_arb.sv
// plic granule arbiter
// reduces four candidates to one, picking the highest priority.
// equal priorities go to the lowest entry index, which also is the
// lowest id since ids are laid out in rising order
`timescale 1ns/1ps
`default_nettype none

`include "plic_defines.svh"

module plic_granu_arb (
  input  wire plic_pkg::plic_int_info_t int_in [`PLIC_SEL_NUM],
  output plic_pkg::plic_int_info_t      int_out
);

  localparam int SEL_NUM  = `PLIC_SEL_NUM;
  localparam int PRIO_BIT = `PLIC_PRIO_BIT;
  localparam int PRIO_NUM = 1 << PRIO_BIT;

  // expanded priority, one row per entry
  logic [PRIO_NUM-1:0]     exp_prio [SEL_NUM];
  // transposed, one entry word per level
  logic [SEL_NUM-1:0]      prio_pos [PRIO_NUM];
  logic [PRIO_NUM-1:0]     valid_prio;
  logic [SEL_NUM-1:0]      high_prio_pos;
  logic [PRIO_BIT-1:0]     high_prio;
  // reversed entry order for the id pick
  plic_pkg::plic_id_t      id_rev [SEL_NUM];
  logic [SEL_NUM-1:0]      pos_rev;
  plic_pkg::plic_id_t      sel_id;
  logic [SEL_NUM-1:0]      req_vec;

  //******************************
  // expand and transpose
  //******************************
  always_comb
  begin
    for (int i = 0; i < SEL_NUM; i++)
    begin
      req_vec[i] = int_in[i].req;
      for (int j = 0; j < PRIO_NUM; j++)
      begin
        exp_prio[i][j] = int_in[i].req && (int_in[i].prio == plic_pkg::plic_prio_t'(j));
        prio_pos[j][i] = exp_prio[i][j];
      end
    end
  end

  // a level is valid when any entry holds it
  always_comb
  begin
    for (int j = 0; j < PRIO_NUM; j++)
    begin
      valid_prio[j] = |prio_pos[j];
    end
  end

  // highest occupied level and its entries
  plic_prio_sel #(
    .data_t (logic [SEL_NUM-1:0]),
    .SEL    (PRIO_NUM)
  ) x_priority_select (
    .data_in  (prio_pos),
    .sel_in   (valid_prio),
    .data_out (high_prio_pos),
    .pos_out  (high_prio)
  );

  //******************************
  // tie break on lowest index
  //******************************
  // selector favours the top bit, so flip the entry order
  always_comb
  begin
    for (int m = 0; m < SEL_NUM; m++)
    begin
      id_rev[SEL_NUM-1-m]  = int_in[m].id;
      pos_rev[SEL_NUM-1-m] = high_prio_pos[m];
    end
  end

  // winning position itself is not needed downstream
  plic_prio_sel #(
    .data_t (plic_pkg::plic_id_t),
    .SEL    (SEL_NUM)
  ) x_id_select (
    .data_in  (id_rev),
    .sel_in   (pos_rev),
    .data_out (sel_id),
    .pos_out  ()
  );

  assign int_out.req  = |req_vec;
  assign int_out.id   = sel_id;
  assign int_out.prio = high_prio;

endmodule

`default_nettype wire

// File: design/plic_prio_sel.sv
// plic priority selector
// finds the highest set bit of the select word and returns the
// payload at that position together with the position itself.
// outputs are zero when no select bit is set
`timescale 1ns/1ps
`default_nettype none

module plic_prio_sel #(
  parameter type data_t = logic [3:0],
  parameter int  SEL    = 4
) (
  input  wire data_t            data_in [SEL],
  input  wire logic [SEL-1:0]   sel_in,
  output data_t                 data_out,
  output logic [$clog2(SEL)-1:0] pos_out
);

  localparam int DATA_BIT = $bits(data_t);
  localparam int POS_BIT  = $clog2(SEL);

  logic [SEL-1:0] smear;
  logic [SEL-1:0] onehot;

  //******************************
  // smear downward, 0110 -> 0111
  //******************************
  always_comb
  begin
    smear[SEL-1] = sel_in[SEL-1];
    for (int k = SEL - 2; k >= 0; k--)
    begin
      smear[k] = smear[k+1] | sel_in[k];
    end
  end

  // keep only the top bit, 0111 -> 0100
  assign onehot = smear & ~(smear >> 1);

  //******************************
  // masked or of payload and position
  //******************************
  always_comb
  begin
    data_out = '0;
    pos_out  = '0;
    for (int n = 0; n < SEL; n++)
    begin
      // at most one term survives the mask
      data_out = data_t'(data_out | ({DATA_BIT{onehot[n]}} & data_in[n]));
      pos_out  = pos_out | ({POS_BIT{onehot[n]}} & POS_BIT'(n));
    end
  end

endmodule

`default_nettype wire

// File: common/plic_pkg.sv
// plic shared types
// scalar id and priority types plus the interrupt-information
// struct passed between gateway, arbiter levels and hart controller
`default_nettype none

`include "plic_defines.svh"

package plic_pkg;

  //******************************
  // scalar types
  //******************************
  // interrupt id, 0 means no interrupt
  typedef logic [`PLIC_ID_BIT-1:0] plic_id_t;

  // priority level
  typedef logic [`PLIC_PRIO_BIT-1:0] plic_prio_t;

  //******************************
  // arbiter candidate
  //******************************
  // one candidate between arbiter stages
  // req  pending with priority above 0
  // id   fixed source id
  // prio current priority of the source
  typedef struct packed {
    logic       req;
    plic_id_t   id;
    plic_prio_t prio;
  } plic_int_info_t;

endpackage

`default_nettype wire

// File: common/plic_defines.svh
// plic sizing macros
// source count, id and priority widths, and the fan-in
// of one granule arbiter in the arbitration tree
`ifndef PLIC_DEFINES_SVH
`define PLIC_DEFINES_SVH

//******************************
// sources
//******************************
// interrupt sources, ids 1..16
`define PLIC_SRC_NUM 16

// id width, id 0 reserved for "none"
`define PLIC_ID_BIT 5

//******************************
// priority
//******************************
// 3 bits, level 0 never interrupts
`define PLIC_PRIO_BIT 3

//******************************
// granule arbiter
//******************************
// entries reduced by one granule arbiter
`define PLIC_SEL_NUM 4

// position width inside a granule
`define PLIC_SEL_BIT 2

`endif
